// ==== build.f ====
src/fe_pkg.sv
src/prefetch_buffer.sv
src/instr_aligner.sv
src/instr_decoder.sv
src/jump_unit.sv
src/fetch_frontend.sv
tests/tb_clock_gen.sv
tests/tb_fetch_frontend.sv

// ==== src/fe_pkg.sv ====
// fetch front end shared definitions
// instruction classes, aligner states and the fixed constants of the front end

package fe_pkg;

  //////////////////////////////
  // constants
  //////////////////////////////

  // pc loaded by reset
  localparam logic [31:0] BOOT_ADDR = 32'h0000_0000;

  // prefetch queue size, in 32-bit words
  localparam int unsigned FIFO_DEPTH = 2;
  // queue pointer and occupancy widths
  localparam int unsigned FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // major opcode of jal
  localparam logic [6:0] OPC_JAL = 7'b110_1111;

  // compressed quadrant 1 and the funct3 of c.j inside it
  localparam logic [1:0] C_QUADRANT1 = 2'b01;
  localparam logic [2:0] C_J_FUNCT3  = 3'b101;

  //////////////////////////////
  // types
  //////////////////////////////

  // class of one aligned instruction
  typedef enum logic [1:0] {
    // anything that falls through to the next pc
    IC_SEQ     = 2'd0,
    // 32-bit jal
    IC_JAL     = 2'd1,
    // compressed c.j
    IC_CJ      = 2'd2,
    // all-zero 16-bit parcel
    IC_ILLEGAL = 2'd3
  } iclass_e;

  // aligner FSM states
  typedef enum logic [2:0] {
    // next instruction starts at the low half of the queue head
    ALIGNED32         = 3'd0,
    // next instruction starts at the saved upper halfword
    MISALIGNED32      = 3'd1,
    // a misaligned 16-bit instr was just taken, head word still unread
    MISALIGNED16      = 3'd2,
    // jumped to the upper half of a word, waiting for that word
    BRANCH_MISALIGNED = 3'd3,
    // jumped to a word boundary, waiting for that word
    WAIT_VALID_BRANCH = 3'd4
  } align_state_e;

endpackage

// ==== src/fetch_frontend.sv ====
// fetch front end top
// prefetch buffer, aligner, decoder and jump unit for an rv32ic core

`timescale 1ns/1ps

module fetch_frontend (
  input  logic            clk,
  input  logic            rst_n,
  output logic            imem_req_o,
  output logic [31:0]     imem_addr_o,
  input  logic            imem_gnt_i,
  input  logic            imem_rvalid_i,
  input  logic [31:0]     imem_rdata_i,
  input  logic            id_ready_i,
  input  logic            redirect_i,
  input  logic [31:0]     redirect_addr_i,
  output logic            instr_valid_o,
  output logic [31:0]     instr_o,
  output logic [31:0]     pc_o,
  output logic            compressed_o,
  output fe_pkg::iclass_e iclass_o
);

  logic        fetch_valid;
  logic [31:0] fetch_rdata;
  logic        aligner_ready;
  logic        fetch_pop;
  logic        branch;
  logic [31:0] branch_addr;
  logic [31:0] jump_imm;

  // head leaves the queue once the aligner is done with it
  assign fetch_pop = fetch_valid & aligner_ready & id_ready_i & ~branch;

  prefetch_buffer u_prefetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .pop_i         (fetch_pop),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_gnt_i    (imem_gnt_i),
    .imem_rvalid_i (imem_rvalid_i),
    .imem_rdata_i  (imem_rdata_i),
    .valid_o       (fetch_valid),
    .rdata_o       (fetch_rdata)
  );

  instr_aligner u_aligner (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_valid_i   (fetch_valid),
    .fetch_rdata_i   (fetch_rdata),
    .aligner_ready_o (aligner_ready),
    .if_valid_i      (id_ready_i),
    .branch_i        (branch),
    .branch_addr_i   (branch_addr),
    .instr_valid_o   (instr_valid_o),
    .instr_aligned_o (instr_o),
    .pc_o            (pc_o)
  );

  instr_decoder u_decoder (
    .instr_i      (instr_o),
    .compressed_o (compressed_o),
    .iclass_o     (iclass_o),
    .imm_o        (jump_imm)
  );

  // one branch source feeds both the queue flush and the aligner pc
  jump_unit u_jump (
    .instr_valid_i   (instr_valid_o),
    .id_ready_i      (id_ready_i),
    .iclass_i        (iclass_o),
    .imm_i           (jump_imm),
    .pc_i            (pc_o),
    .redirect_i      (redirect_i),
    .redirect_addr_i (redirect_addr_i),
    .branch_o        (branch),
    .branch_addr_o   (branch_addr)
  );

endmodule

// ==== src/instr_aligner.sv ====
// instruction aligner
// cuts the word stream into 16 and 32 bit instructions and tracks their pc

`timescale 1ns/1ps

module instr_aligner (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_valid_i,
  input  logic [31:0] fetch_rdata_i,
  output logic        aligner_ready_o,
  input  logic        if_valid_i,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  output logic        instr_valid_o,
  output logic [31:0] instr_aligned_o,
  output logic [31:0] pc_o
);
  import fe_pkg::*;

  align_state_e state_q;
  align_state_e state_n;
  logic [31:0]  pc_q;
  logic [31:0]  pc_n;
  logic [31:0]  pc_plus2;
  logic [31:0]  pc_plus4;
  // upper halfword of the last word taken from the queue
  logic [15:0]  instr_hi_q;
  logic         update_state;

  assign pc_o     = pc_q;
  assign pc_plus2 = pc_q + 32'd2;
  assign pc_plus4 = pc_q + 32'd4;

  //////////////////////////////
  // state and pc
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGNED32;
      pc_q    <= BOOT_ADDR;
    end else if (update_state) begin
      state_q <= state_n;
      pc_q    <= pc_n;
    end
  end

  // keep the top half whenever the head word is consumed
  always_ff @(posedge clk) begin
    if (update_state && aligner_ready_o) begin
      instr_hi_q <= fetch_rdata_i[31:16];
    end
  end

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    // defaults, head word taken as a whole
    state_n         = state_q;
    pc_n            = pc_q;
    instr_valid_o   = fetch_valid_i;
    instr_aligned_o = fetch_rdata_i;
    aligner_ready_o = 1'b1;
    update_state    = 1'b0;

    case (state_q)
      // instruction starts at the low half of the head word
      // WAIT_VALID_BRANCH only differs in that the word is the jump target
      ALIGNED32, MISALIGNED16, WAIT_VALID_BRANCH: begin
        update_state = fetch_valid_i & if_valid_i;
        if (fetch_rdata_i[1:0] == 2'b11) begin
          // whole word is one instruction
          state_n = ALIGNED32;
          pc_n    = pc_plus4;
        end else begin
          // 16-bit in the low half, the upper half starts the next one
          instr_aligned_o = {16'h0000, fetch_rdata_i[15:0]};
          state_n         = MISALIGNED32;
          pc_n            = pc_plus2;
        end
      end

      // instruction starts at the saved upper halfword
      MISALIGNED32: begin
        if (instr_hi_q[1:0] == 2'b11) begin
          // 32-bit straddling two words, needs the low half of the head
          instr_aligned_o = {fetch_rdata_i[15:0], instr_hi_q};
          state_n         = MISALIGNED32;
          pc_n            = pc_plus4;
          update_state    = fetch_valid_i & if_valid_i;
        end else begin
          // 16-bit entirely in the saved half
          // head word is not touched, it holds the next instruction
          instr_aligned_o = {16'h0000, instr_hi_q};
          instr_valid_o   = 1'b1;
          aligner_ready_o = 1'b0;
          state_n         = MISALIGNED16;
          pc_n            = pc_plus2;
          update_state    = if_valid_i;
        end
      end

      // jump target is the upper half of the head word
      BRANCH_MISALIGNED: begin
        update_state = fetch_valid_i & if_valid_i;
        if (fetch_rdata_i[17:16] == 2'b11) begin
          // 32-bit target, only its low half is here
          // swallow the word silently and finish it from the next one
          instr_valid_o = 1'b0;
          state_n       = MISALIGNED32;
          pc_n          = pc_q;
        end else begin
          // 16-bit target uses up the word
          instr_aligned_o = {16'h0000, fetch_rdata_i[31:16]};
          state_n         = ALIGNED32;
          pc_n            = pc_plus2;
        end
      end

      default: begin
        state_n      = ALIGNED32;
        update_state = 1'b0;
      end
    endcase

    // jump or redirect wins over the normal step
    if (branch_i) begin
      update_state = 1'b1;
      pc_n         = branch_addr_i;
      state_n      = branch_addr_i[1] ? BRANCH_MISALIGNED : WAIT_VALID_BRANCH;
    end
  end

endmodule

// ==== src/instr_decoder.sv ====
// instruction decoder
// classifies an aligned instruction and extracts the jump offset

`timescale 1ns/1ps

module instr_decoder (
  input  logic [31:0]     instr_i,
  output logic            compressed_o,
  output fe_pkg::iclass_e iclass_o,
  output logic [31:0]     imm_o
);
  import fe_pkg::*;

  logic [6:0]  opcode;
  logic [1:0]  quadrant;
  logic [2:0]  c_funct3;
  logic [31:0] imm_j;
  logic [31:0] imm_cj;

  // 32-bit encodings have both low bits set
  assign compressed_o = (instr_i[1:0] != 2'b11);

  assign opcode   = instr_i[6:0];
  assign quadrant = instr_i[1:0];
  assign c_funct3 = instr_i[15:13];

  //////////////////////////////
  // immediates
  //////////////////////////////

  // j-type offset, imm[20|10:1|11|19:12] in bits 31:12
  assign imm_j = {
    {12{instr_i[31]}},
    instr_i[19:12],
    instr_i[20],
    instr_i[30:21],
    1'b0
  };

  // cj-type offset, imm[11|4|9:8|10|6|7|3:1|5] in bits 12:2
  assign imm_cj = {
    {21{instr_i[12]}},
    instr_i[8],
    instr_i[10:9],
    instr_i[6],
    instr_i[7],
    instr_i[2],
    instr_i[11],
    instr_i[5:3],
    1'b0
  };

  //////////////////////////////
  // class
  //////////////////////////////

  always_comb begin
    iclass_o = IC_SEQ;
    imm_o    = 32'h0000_0000;
    if (!compressed_o) begin
      if (opcode == OPC_JAL) begin
        iclass_o = IC_JAL;
        imm_o    = imm_j;
      end
    end else if (instr_i[15:0] == 16'h0000) begin
      // defined illegal parcel
      iclass_o = IC_ILLEGAL;
    end else if ((quadrant == C_QUADRANT1) && (c_funct3 == C_J_FUNCT3)) begin
      iclass_o = IC_CJ;
      imm_o    = imm_cj;
    end
  end

endmodule

// ==== src/jump_unit.sv ====
// jump unit
// resolves jal and c.j in the front end and merges the external redirect

`timescale 1ns/1ps

module jump_unit (
  input  logic            instr_valid_i,
  input  logic            id_ready_i,
  input  fe_pkg::iclass_e iclass_i,
  input  logic [31:0]     imm_i,
  input  logic [31:0]     pc_i,
  input  logic            redirect_i,
  input  logic [31:0]     redirect_addr_i,
  output logic            branch_o,
  output logic [31:0]     branch_addr_o
);
  import fe_pkg::*;

  logic        is_jump;
  logic        jump_taken;
  logic [31:0] jump_target;

  // pc relative target, always on a halfword
  assign jump_target = pc_i + imm_i;

  assign is_jump    = (iclass_i == IC_JAL) || (iclass_i == IC_CJ);
  // only a jump that the consumer actually takes
  assign jump_taken = instr_valid_i & id_ready_i & is_jump;

  // later stage redirect is older, so it wins
  assign branch_o      = redirect_i | jump_taken;
  assign branch_addr_o = redirect_i ? redirect_addr_i : {jump_target[31:1], 1'b0};

endmodule

// ==== src/prefetch_buffer.sv ====
// prefetch buffer
// fetches instruction words one request at a time into a small queue,
// flushes on a branch and drops a response that was requested before the flush

`timescale 1ns/1ps

module prefetch_buffer (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  input  logic        pop_i,
  output logic        imem_req_o,
  output logic [31:0] imem_addr_o,
  input  logic        imem_gnt_i,
  input  logic        imem_rvalid_i,
  input  logic [31:0] imem_rdata_i,
  output logic        valid_o,
  output logic [31:0] rdata_o
);
  import fe_pkg::*;

  logic                  en_q;
  logic [31:0]           fetch_addr_q;
  logic                  outstanding_q;
  logic                  drop_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [31:0]           q_mem [FIFO_DEPTH];
  logic                  grant;
  logic                  push;
  logic                  pop;

  // pointer step with wrap at the queue depth
  function automatic logic [FIFO_PTR_W-1:0] ptr_next(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////
  // memory request side
  //////////////////////////////

  // one request in flight at most, and only with room for its answer
  // no new fetch in a branch cycle, the address is about to change
  assign imem_req_o  = en_q && !outstanding_q && (count_q < FIFO_CNT_W'(FIFO_DEPTH)) &&
                       !branch_i;
  assign imem_addr_o = fetch_addr_q;
  assign grant       = imem_req_o & imem_gnt_i;

  // response goes into the queue unless it belongs to a flushed fetch
  assign push = imem_rvalid_i & outstanding_q & ~drop_q & ~branch_i;
  assign pop  = pop_i & valid_o;

  // head of the queue towards the aligner
  assign valid_o = (count_q != '0);
  assign rdata_o = q_mem[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q          <= 1'b0;
      fetch_addr_q  <= BOOT_ADDR;
      outstanding_q <= 1'b0;
      drop_q        <= 1'b0;
    end else begin
      // fetching starts one edge after reset
      en_q <= 1'b1;

      // branch target word, else next word after each grant
      if (branch_i) begin
        fetch_addr_q <= {branch_addr_i[31:2], 2'b00};
      end else if (grant) begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end

      if (grant) begin
        outstanding_q <= 1'b1;
      end else if (imem_rvalid_i) begin
        outstanding_q <= 1'b0;
      end

      // a fetch still in flight at a flush is stale
      if (imem_rvalid_i) begin
        drop_q <= 1'b0;
      end else if (branch_i && outstanding_q) begin
        drop_q <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // word queue
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q  <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else if (branch_i) begin
      // flush, the target word is fetched next
      count_q  <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // queue storage
  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr_q] <= imem_rdata_i;
    end
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
// testbench clock and reset
// 8 ns clock, reset held low for the first 4 cycles

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // release just after an edge, like every other driven input
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== tests/tb_fetch_frontend.sv ====
// fetch front end testbench
// instruction memory model, reference stream model and directed tests

`timescale 1ns/1ps

module tb_fetch_frontend;
  import fe_pkg::*;

  localparam logic [31:0] SEED        = 32'h599a_7f32;
  localparam int          IDLE_LIMIT  = 100;
  localparam int          RESET_LIMIT = 20;
  localparam int          MEM_WORDS   = 256;

  logic        clk;
  logic        rst_n;
  logic        imem_req_o;
  logic [31:0] imem_addr_o;
  logic        imem_gnt_i    = 1'b0;
  logic        imem_rvalid_i = 1'b0;
  logic [31:0] imem_rdata_i  = 32'h0000_0000;
  logic        id_ready_i;
  logic        redirect_i;
  logic [31:0] redirect_addr_i;
  logic        instr_valid_o;
  logic [31:0] instr_o;
  logic [31:0] pc_o;
  logic        compressed_o;
  iclass_e     iclass_o;

  // program image with one entry per 32-bit word
  logic [31:0] mem [MEM_WORDS];
  // jump offsets written by the program builder per halfword
  logic [31:0] jump_off [2*MEM_WORDS];
  // program builder cursor
  logic [31:0] cur;

  // expected stream from the reference model
  logic [31:0] exp_pc [$];
  logic [31:0] exp_instr [$];
  logic        exp_comp [$];
  iclass_e     exp_cls [$];

  // memory model state
  logic        resp_pending = 1'b0;
  logic [31:0] resp_addr    = 32'h0000_0000;
  logic [1:0]  resp_wait    = 2'd0;
  logic        stall_en     = 1'b0;
  logic [31:0] rng_mem      = SEED;
  logic [31:0] rng_rdy;

  int          errors  = 0;
  int          checks  = 0;
  logic        aborted = 1'b0;

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fetch_frontend dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .imem_req_o      (imem_req_o),
    .imem_addr_o     (imem_addr_o),
    .imem_gnt_i      (imem_gnt_i),
    .imem_rvalid_i   (imem_rvalid_i),
    .imem_rdata_i    (imem_rdata_i),
    .id_ready_i      (id_ready_i),
    .redirect_i      (redirect_i),
    .redirect_addr_i (redirect_addr_i),
    .instr_valid_o   (instr_valid_o),
    .instr_o         (instr_o),
    .pc_o            (pc_o),
    .compressed_o    (compressed_o),
    .iclass_o        (iclass_o)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // addi x1, x1, k
  function automatic logic [31:0] addi32(input logic [11:0] k);
    return {k, 5'd1, 3'b000, 5'd1, 7'b001_0011};
  endfunction

  // c.addi x1, k in quadrant 1
  function automatic logic [15:0] caddi16(input logic [4:0] k);
    return {3'b000, 1'b0, 5'd1, k, 2'b01};
  endfunction

  function automatic logic [15:0] half_at(input logic [31:0] addr);
    if (addr[1]) begin
      return mem[addr[9:2]][31:16];
    end
    return mem[addr[9:2]][15:0];
  endfunction

  task automatic put16(input logic [31:0] addr, input logic [15:0] h);
    if (addr[1]) begin
      mem[addr[9:2]][31:16] = h;
    end else begin
      mem[addr[9:2]][15:0] = h;
    end
  endtask

  task automatic emit16(input logic [15:0] h);
    put16(cur, h);
    cur = cur + 32'd2;
  endtask

  // halves go in separately so a word boundary may fall inside
  task automatic emit32(input logic [31:0] w);
    put16(cur, w[15:0]);
    put16(cur + 32'd2, w[31:16]);
    cur = cur + 32'd4;
  endtask

  // jal x0 to an absolute target in j-type layout
  task automatic emit_jal(input logic [31:0] target);
    logic [31:0] off;
    off = target - cur;
    jump_off[cur[9:1]] = off;
    emit32({off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b110_1111});
  endtask

  // c.j to an absolute target in cj-type layout
  task automatic emit_cj(input logic [31:0] target);
    logic [31:0] off;
    off = target - cur;
    jump_off[cur[9:1]] = off;
    emit16({3'b101, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1],
            off[5], 2'b01});
  endtask

  // fills the skipped shadow of a jump
  task automatic pad_to(input logic [31:0] addr);
    while (cur < addr) begin
      emit16(caddi16(5'd31));
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic iclass_e classify(input logic [31:0] ins, input logic comp);
    if (!comp) begin
      if (ins[6:0] == 7'b110_1111) begin
        return IC_JAL;
      end
      return IC_SEQ;
    end
    if (ins[15:0] == 16'h0000) begin
      return IC_ILLEGAL;
    end
    if ((ins[1:0] == 2'b01) && (ins[15:13] == 3'b101)) begin
      return IC_CJ;
    end
    return IC_SEQ;
  endfunction

  // walk the image halfword by halfword and follow the jumps
  task automatic build_expected(input logic [31:0] start, input int n);
    logic [31:0] pc;
    logic [15:0] lo;
    logic [31:0] ins;
    logic        comp;
    iclass_e     cls;
    pc = start;
    for (int k = 0; k < n; k++) begin
      lo   = half_at(pc);
      comp = (lo[1:0] != 2'b11);
      ins  = comp ? {16'h0000, lo} : {half_at(pc + 32'd2), lo};
      cls  = classify(ins, comp);
      exp_pc.push_back(pc);
      exp_instr.push_back(ins);
      exp_comp.push_back(comp);
      exp_cls.push_back(cls);
      if ((cls == IC_JAL) || (cls == IC_CJ)) begin
        pc = pc + jump_off[pc[9:1]];
      end else begin
        pc = pc + (comp ? 32'd2 : 32'd4);
      end
    end
  endtask

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s expected %08h, got %08h", $time, what, exp, got);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s expected %b, got %b", $time, what, exp, got);
    end
  endtask

  task automatic check_iclass(input string what, input fe_pkg::iclass_e exp,
                              input fe_pkg::iclass_e got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s expected %s, got %s (%0d)", $time, what, exp.name(),
               got.name(), got);
    end
  endtask

  // one accepted instruction against the head of the expected stream
  task automatic check_accept(input string tag);
    check_word({tag, " pc"}, exp_pc.pop_front(), pc_o);
    check_word({tag, " instr"}, exp_instr.pop_front(), instr_o);
    check_bit({tag, " compressed"}, exp_comp.pop_front(), compressed_o);
    check_iclass({tag, " class"}, exp_cls.pop_front(), iclass_o);
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////

  // grants sampled mid cycle and answered at least one cycle later
  always begin
    @(posedge clk);
    #1;
    imem_rvalid_i = 1'b0;
    if (resp_pending) begin
      if (resp_wait == 2'd0) begin
        imem_rvalid_i = 1'b1;
        imem_rdata_i  = mem[resp_addr[9:2]];
        resp_pending  = 1'b0;
      end else begin
        resp_wait = resp_wait - 2'd1;
      end
    end
    if (stall_en) begin
      rng_mem    = xorshift32(rng_mem);
      imem_gnt_i = (rng_mem[1:0] != 2'b00);
    end else begin
      imem_gnt_i = 1'b1;
    end
    @(negedge clk);
    if (imem_req_o && imem_gnt_i) begin
      if (resp_pending) begin
        errors++;
        $display("a second memory request was granted while one was still outstanding");
      end
      check_word("imem address low bits", 32'h0, {30'h0, imem_addr_o[1:0]});
      resp_pending = 1'b1;
      resp_addr    = imem_addr_o;
      resp_wait    = stall_en ? rng_mem[3:2] : 2'd0;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // no fetch request and no instruction while reset is held
  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while ((rst_n !== 1'b1) && !aborted) begin
      @(negedge clk);
      if (rst_n !== 1'b1) begin
        check_bit("imem_req_o in reset", 1'b0, imem_req_o);
        check_bit("instr_valid_o in reset", 1'b0, instr_valid_o);
      end
      cycles++;
      if (cycles > RESET_LIMIT) begin
        errors++;
        aborted = 1'b1;
        $display("reset was never released");
      end
    end
  endtask

  // one cycle pulse while the consumer is stalled
  task automatic redirect_to(input logic [31:0] addr);
    @(posedge clk);
    #1;
    id_ready_i      = 1'b0;
    redirect_i      = 1'b1;
    redirect_addr_i = addr;
    @(posedge clk);
    #1;
    redirect_i = 1'b0;
  endtask

  // accept n instructions with a timeout on each one
  task automatic collect(input int n, input logic rand_ready, input string tag);
    int got;
    int idle;
    got  = 0;
    idle = 0;
    while ((got < n) && !aborted) begin
      @(posedge clk);
      #1;
      if (rand_ready) begin
        rng_rdy    = xorshift32(rng_rdy);
        id_ready_i = (rng_rdy[1:0] != 2'b00);
      end else begin
        id_ready_i = 1'b1;
      end
      @(negedge clk);
      if (instr_valid_o && id_ready_i) begin
        check_accept(tag);
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > IDLE_LIMIT) begin
          errors++;
          aborted = 1'b1;
          $display("%s timed out waiting for instruction %0d of %0d", tag, got + 1, n);
          $display("  aligner state %s, pc %08h", dut_i.u_aligner.state_q.name(), pc_o);
        end
      end
    end
    exp_pc.delete();
    exp_instr.delete();
    exp_comp.delete();
    exp_cls.delete();
  endtask

  task automatic load_programs();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {8'(i), 8'h5a ^ 8'(i), ~8'(i), 8'(i) ^ 8'h3c};
    end
    for (int i = 0; i < 2 * MEM_WORDS; i++) begin
      jump_off[i] = 32'h0000_0000;
    end
    // straight line of 32-bit words at the boot pc
    cur = BOOT_ADDR;
    for (int k = 1; k <= 6; k++) begin
      emit32(addi32(12'(k)));
    end
    // mixed widths where several 32-bit instrs straddle words
    cur = 32'h0000_0100;
    emit16(caddi16(5'd1));
    emit32(addi32(12'd2));
    emit16(caddi16(5'd3));
    emit16(caddi16(5'd4));
    emit32(addi32(12'd5));
    emit32(addi32(12'd6));
    emit16(16'h0000);
    emit32(addi32(12'd7));
    emit16(caddi16(5'd8));
    emit16(caddi16(5'd9));
    emit32(addi32(12'd10));
    // jumps to word and halfword targets with the last one backwards
    cur = 32'h0000_0200;
    emit32(addi32(12'd1));
    emit_jal(32'h0000_0210);
    pad_to(32'h0000_0210);
    emit16(caddi16(5'd2));
    emit_cj(32'h0000_021e);
    pad_to(32'h0000_021e);
    emit32(addi32(12'd3));
    emit_jal(32'h0000_0242);
    pad_to(32'h0000_0242);
    emit16(caddi16(5'd4));
    emit_cj(32'h0000_01f0);
    cur = 32'h0000_01f0;
    emit32(addi32(12'd5));
    emit16(caddi16(5'd6));
    emit32(addi32(12'd7));
    // stream cut by a redirect and then the misaligned target
    cur = 32'h0000_0300;
    emit16(caddi16(5'd1));
    emit32(addi32(12'd2));
    emit16(caddi16(5'd3));
    emit32(addi32(12'd4));
    emit32(addi32(12'd5));
    emit16(caddi16(5'd6));
    emit32(addi32(12'd7));
    emit16(caddi16(5'd8));
    cur = 32'h0000_0382;
    emit32(addi32(12'd11));
    emit16(caddi16(5'd12));
    emit32(addi32(12'd13));
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_straight32();
    build_expected(BOOT_ADDR, 6);
    collect(6, 1'b0, "straight32");
  endtask

  task automatic test_mixed();
    redirect_to(32'h0000_0100);
    build_expected(32'h0000_0100, 11);
    collect(11, 1'b0, "mixed");
  endtask

  task automatic test_jumps();
    redirect_to(32'h0000_0200);
    build_expected(32'h0000_0200, 11);
    collect(11, 1'b0, "jumps");
  endtask

  // prefetched words past the cut must never show up
  task automatic test_redirect();
    redirect_to(32'h0000_0300);
    build_expected(32'h0000_0300, 3);
    collect(3, 1'b0, "redirect head");
    redirect_to(32'h0000_0382);
    build_expected(32'h0000_0382, 3);
    collect(3, 1'b0, "redirect target");
  endtask

  // mixed program again under grant stalls and consumer drops
  task automatic test_stress();
    stall_en = 1'b1;
    repeat (3) begin
      redirect_to(32'h0000_0100);
      build_expected(32'h0000_0100, 11);
      collect(11, 1'b1, "stress");
    end
    stall_en = 1'b0;
  endtask

  initial begin
    id_ready_i      = 1'b0;
    redirect_i      = 1'b0;
    redirect_addr_i = 32'h0000_0000;
    rng_rdy         = xorshift32(SEED);
    load_programs();
    wait_reset();
    test_straight32();
    test_mixed();
    test_jumps();
    test_redirect();
    test_stress();
    $display("checks: %0d, errors: %0d", checks, errors);
    if ((errors == 0) && !aborted && (checks > 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
